/* compile.f */
+incdir+.
pq_pkg.sv
pifo_cell.sv
sorted_list.sv
pq_admit.sv
pq_top.sv
tb_pq_top.sv

/* pifo_cell.sv */
`include "pq_defs.svh"

module pifo_cell
#(
	parameter int SLOT_INDEX = 0
)
(
	input logic clk,
	input logic rst,
	input logic cell_ins,
	input logic cell_rem,
	input pq_pkg::entry_t cell_entry,
	input pq_pkg::slot_t [`PQ_REG_SIZE-1:0] slots,
	output pq_pkg::slot_t slot
);

	import pq_pkg::*;

	slot_t left_slot;
	slot_t right_slot;
	logic left_above;
	logic self_above;

	// Neighbours at the ends of the row are empty
	generate
		if (SLOT_INDEX == 0)
		begin : g_first
			assign left_slot = '0;
		end
		else
		begin : g_left
			assign left_slot = slots[SLOT_INDEX-1];
		end

		if (SLOT_INDEX == `PQ_REG_SIZE-1)
		begin : g_last
			assign right_slot = '0;
		end
		else
		begin : g_right
			assign right_slot = slots[SLOT_INDEX+1];
		end
	endgenerate

	// Equal ranks are not above, so a new entry lands behind them
	assign left_above = (SLOT_INDEX != 0) &&
		(!left_slot.valid || (left_slot.entry.rank > cell_entry.rank));
	assign self_above = !slot.valid || (slot.entry.rank > cell_entry.rank);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			slot.valid <= 1'b0;
		end
		else if (cell_rem)
		begin
			// Shift toward slot 0, last slot drains to empty
			slot <= right_slot;
		end
		else if (cell_ins)
		begin
			if (left_above)
			begin
				slot <= left_slot;
			end
			else if (self_above)
			begin
				slot.entry <= cell_entry;
				slot.valid <= 1'b1;
			end
		end
	end

endmodule

/* pq_admit.sv */
`include "pq_defs.svh"

module pq_admit
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input pq_pkg::entry_t in_entry,
	output logic out_valid,
	input logic out_ready,
	input pq_pkg::slot_t [`PQ_REG_SIZE-1:0] slots,
	output logic cell_ins,
	output logic cell_rem,
	output pq_pkg::entry_t cell_entry,
	output logic push_valid,
	input logic push_ready,
	output pq_pkg::entry_t push_entry,
	input pq_pkg::slot_t head,
	output logic pop,
	input pq_pkg::count_t list_count,
	output pq_pkg::count_t num_entries
);

	import pq_pkg::*;

	localparam count_t CAPACITY = count_t'((1 << `PQ_L2_LIST_SIZE) + `PQ_REG_SIZE);

	admit_state_e state;
	count_t reg_count;
	slot_t last_slot;
	logic full;
	logic in_fire;
	logic out_fire;
	logic to_bank;

	assign last_slot = slots[`PQ_REG_SIZE-1];
	assign num_entries = reg_count + list_count;
	assign full = (num_entries == CAPACITY);

	// Slot 0 is the minimum, hidden while a refill is pending
	assign out_valid = (state == ADM_IDLE) && slots[0].valid;
	assign out_fire = out_valid && out_ready;

	// Removal wins when both sides are offered in the same cycle
	assign in_ready = (state == ADM_IDLE) && push_ready && !full && !out_fire;
	assign in_fire = in_valid && in_ready;

	// New entry belongs in the bank if there is room or it beats the last slot
	assign to_bank = !last_slot.valid || (in_entry.rank < last_slot.entry.rank);

	always_comb
	begin
		cell_ins = 1'b0;
		cell_rem = 1'b0;
		cell_entry = in_entry;
		push_valid = 1'b0;
		push_entry = in_entry;
		pop = 1'b0;
		case (state)
			ADM_IDLE:
			begin
				if (out_fire)
				begin
					cell_rem = 1'b1;
				end
				else if (in_fire)
				begin
					cell_ins = to_bank;
					// Full bank evicts the larger of the two into the list
					push_valid = last_slot.valid;
					push_entry = to_bank ? last_slot.entry : in_entry;
				end
			end
			ADM_REFILL:
			begin
				if (head.valid)
				begin
					cell_ins = 1'b1;
					cell_entry = head.entry;
					pop = 1'b1;
				end
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ADM_IDLE;
			reg_count <= '0;
		end
		else
		begin
			case (state)
				ADM_IDLE:
				begin
					if (out_fire)
					begin
						reg_count <= reg_count - 1'b1;
						if (list_count != '0)
						begin
							state <= ADM_REFILL;
						end
					end
					else if (in_fire)
					begin
						if (!last_slot.valid)
						begin
							reg_count <= reg_count + 1'b1;
						end
						else
						begin
							state <= ADM_LIST_WAIT;
						end
					end
				end
				// List drops push_ready for at least one cycle per push
				ADM_LIST_WAIT:
				begin
					if (push_ready)
					begin
						state <= ADM_IDLE;
					end
				end
				ADM_REFILL:
				begin
					if (head.valid)
					begin
						reg_count <= reg_count + 1'b1;
						state <= ADM_IDLE;
					end
				end
				default:
				begin
					state <= ADM_IDLE;
				end
			endcase
		end
	end

endmodule

/* pq_defs.svh */
`ifndef PQ_DEFS_SVH
`define PQ_DEFS_SVH

// Entry fields
`define PQ_RANK_WIDTH 10
`define PQ_META_WIDTH 10

// Overflow list holds 2**PQ_L2_LIST_SIZE nodes
`define PQ_L2_LIST_SIZE 5

// Sorted register bank in front of the list
`define PQ_REG_SIZE 4

// Next pointer written into the last node of the list
`define PQ_NULL_PTR {`PQ_L2_LIST_SIZE{1'b1}}

`endif

/* pq_pkg.sv */
`include "pq_defs.svh"

package pq_pkg;

	// One queued element
	typedef struct packed
	{
		logic [`PQ_RANK_WIDTH-1:0] rank;
		logic [`PQ_META_WIDTH-1:0] meta;
	} entry_t;

	// Register bank slot
	typedef struct packed
	{
		entry_t entry;
		logic valid;
	} slot_t;

	typedef logic [`PQ_L2_LIST_SIZE-1:0] node_ptr_t;

	// Node memory word, singly linked in rank order
	typedef struct packed
	{
		entry_t entry;
		node_ptr_t next;
	} list_node_t;

	// Bank plus list, one extra bit over the list index
	typedef logic [`PQ_L2_LIST_SIZE:0] count_t;

	typedef enum logic [1:0]
	{
		ADM_IDLE,
		ADM_LIST_WAIT,
		ADM_REFILL
	} admit_state_e;

	typedef enum logic [2:0]
	{
		LST_INIT,
		LST_IDLE,
		LST_WALK_RD,
		LST_WALK,
		LST_LINK,
		LST_POP_RD
	} list_state_e;

endpackage

/* pq_top.sv */
`include "pq_defs.svh"

module pq_top
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input pq_pkg::entry_t in_entry,
	output logic out_valid,
	input logic out_ready,
	output pq_pkg::entry_t out_entry,
	output pq_pkg::count_t num_entries
);

	import pq_pkg::*;

	slot_t [`PQ_REG_SIZE-1:0] slots;
	logic cell_ins;
	logic cell_rem;
	entry_t cell_entry;
	logic push_valid;
	logic push_ready;
	entry_t push_entry;
	slot_t head;
	logic pop;
	count_t list_count;

	// Minimum always sits in slot 0
	assign out_entry = slots[0].entry;

	pq_admit u_admit
	(
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_entry    (in_entry),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.slots       (slots),
		.cell_ins    (cell_ins),
		.cell_rem    (cell_rem),
		.cell_entry  (cell_entry),
		.push_valid  (push_valid),
		.push_ready  (push_ready),
		.push_entry  (push_entry),
		.head        (head),
		.pop         (pop),
		.list_count  (list_count),
		.num_entries (num_entries)
	);

	genvar i;
	generate
		for (i = 0; i < `PQ_REG_SIZE; i++)
		begin : g_cell
			pifo_cell #(.SLOT_INDEX(i)) u_cell
			(
				.clk        (clk),
				.rst        (rst),
				.cell_ins   (cell_ins),
				.cell_rem   (cell_rem),
				.cell_entry (cell_entry),
				.slots      (slots),
				.slot       (slots[i])
			);
		end
	endgenerate

	sorted_list u_list
	(
		.clk        (clk),
		.rst        (rst),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.push_entry (push_entry),
		.head       (head),
		.pop        (pop),
		.list_count (list_count)
	);

endmodule

/* sorted_list.sv */
`include "pq_defs.svh"

module sorted_list
(
	input logic clk,
	input logic rst,
	input logic push_valid,
	output logic push_ready,
	input pq_pkg::entry_t push_entry,
	output pq_pkg::slot_t head,
	input logic pop,
	output pq_pkg::count_t list_count
);

	import pq_pkg::*;

	localparam int LIST_SIZE = 1 << `PQ_L2_LIST_SIZE;

	list_state_e state;

	// Node memory, one write port and a registered read
	list_node_t node_mem [LIST_SIZE];
	list_node_t rd_data;
	node_ptr_t rd_addr;
	logic mem_we;
	node_ptr_t mem_waddr;
	list_node_t mem_wdata;

	// Free node FIFO
	node_ptr_t fl_mem [LIST_SIZE];
	node_ptr_t fl_wr;
	node_ptr_t fl_rd;
	logic fl_push;
	node_ptr_t fl_din;
	node_ptr_t init_cnt;

	// Head node kept in registers
	node_ptr_t head_ptr;
	list_node_t head_node;
	logic head_valid;

	// Insert in progress
	entry_t new_entry;
	node_ptr_t new_node;
	node_ptr_t link_next;
	logic link_head;
	node_ptr_t cur;
	list_node_t cur_node;
	count_t walk_left;
	logic insert_here;
	logic push_fire;
	logic pop_fire;

	assign push_ready = (state == LST_IDLE);
	assign push_fire = push_valid && push_ready;
	assign pop_fire = pop && (state == LST_IDLE);

	always_comb
	begin
		head.entry = head_node.entry;
		head.valid = head_valid;
	end

	// Pop reads the second node, a walk reads the node after cur
	assign rd_addr = (state == LST_IDLE) ? head_node.next : cur_node.next;

	// New node goes right after cur when cur is the tail or its successor ranks higher
	always_comb
	begin
		insert_here = 1'b0;
		if (state == LST_WALK_RD)
		begin
			insert_here = (walk_left == '0);
		end
		else if (state == LST_WALK)
		begin
			insert_here = (rd_data.entry.rank > new_entry.rank);
		end
	end

	// Decision cycle relinks cur, the link cycle writes the new node
	always_comb
	begin
		mem_we = insert_here;
		mem_waddr = cur;
		mem_wdata.entry = cur_node.entry;
		mem_wdata.next = new_node;
		if (state == LST_LINK)
		begin
			mem_we = 1'b1;
			mem_waddr = new_node;
			mem_wdata.entry = new_entry;
			mem_wdata.next = link_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_we)
		begin
			node_mem[mem_waddr] <= mem_wdata;
		end
		rd_data <= node_mem[rd_addr];
	end

	// Filled with every index after reset, later fed by popped heads
	assign fl_push = (state == LST_INIT) || pop_fire;
	assign fl_din = (state == LST_INIT) ? init_cnt : head_ptr;

	always_ff @(posedge clk)
	begin
		if (fl_push)
		begin
			fl_mem[fl_wr] <= fl_din;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= LST_INIT;
			init_cnt <= '0;
			fl_wr <= '0;
			fl_rd <= '0;
			head_ptr <= `PQ_NULL_PTR;
			head_valid <= 1'b0;
			list_count <= '0;
		end
		else
		begin
			if (fl_push)
			begin
				fl_wr <= fl_wr + 1'b1;
			end
			case (state)
				LST_INIT:
				begin
					init_cnt <= init_cnt + 1'b1;
					if (init_cnt == node_ptr_t'(LIST_SIZE-1))
					begin
						state <= LST_IDLE;
					end
				end
				LST_IDLE:
				begin
					if (pop_fire)
					begin
						list_count <= list_count - 1'b1;
						head_valid <= 1'b0;
						if (list_count == count_t'(1))
						begin
							head_ptr <= `PQ_NULL_PTR;
						end
						else
						begin
							head_ptr <= head_node.next;
							state <= LST_POP_RD;
						end
					end
					else if (push_fire)
					begin
						new_entry <= push_entry;
						new_node <= fl_mem[fl_rd];
						fl_rd <= fl_rd + 1'b1;
						list_count <= list_count + 1'b1;
						if ((list_count == '0) || (head_node.entry.rank > push_entry.rank))
						begin
							link_head <= 1'b1;
							link_next <= (list_count == '0) ? `PQ_NULL_PTR : head_ptr;
							state <= LST_LINK;
						end
						else
						begin
							link_head <= 1'b0;
							cur <= head_ptr;
							cur_node <= head_node;
							walk_left <= list_count - 1'b1;
							state <= LST_WALK_RD;
						end
					end
				end
				LST_WALK_RD:
				begin
					if (insert_here)
					begin
						link_next <= `PQ_NULL_PTR;
						state <= LST_LINK;
					end
					else
					begin
						state <= LST_WALK;
					end
				end
				LST_WALK:
				begin
					if (insert_here)
					begin
						link_next <= cur_node.next;
						state <= LST_LINK;
					end
					else
					begin
						cur <= cur_node.next;
						cur_node <= rd_data;
						walk_left <= walk_left - 1'b1;
						state <= LST_WALK_RD;
					end
				end
				LST_LINK:
				begin
					if (link_head)
					begin
						head_ptr <= new_node;
						head_node.entry <= new_entry;
						head_node.next <= link_next;
						head_valid <= 1'b1;
					end
					state <= LST_IDLE;
				end
				LST_POP_RD:
				begin
					head_node <= rd_data;
					head_valid <= 1'b1;
					state <= LST_IDLE;
				end
				default:
				begin
					state <= LST_IDLE;
				end
			endcase
			// Keep the cached head in step when the head node gains a successor
			if (insert_here && (cur == head_ptr))
			begin
				head_node.next <= new_node;
			end
		end
	end

endmodule

/* tb_pq_top.sv */
`include "pq_defs.svh"

module tb_pq_top;

	timeunit 1ns;
	timeprecision 1ps;

	import pq_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int CAPACITY = (1 << `PQ_L2_LIST_SIZE) + `PQ_REG_SIZE;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	entry_t in_entry;
	logic out_valid;
	logic out_ready;
	entry_t out_entry;
	count_t num_entries;

	// Expected contents, kept stable-sorted by rank
	entry_t model[$];
	int mismatches;
	int timeouts;

	pq_top UUT
	(
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_entry    (in_entry),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_entry   (out_entry),
		.num_entries (num_entries)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk;
		end
	end

	task automatic check_entry(input string name, input entry_t exp, input entry_t act);
		if (exp !== act)
		begin
			$display("FAIL t=%0t %s expected rank %0d meta %0d, got rank %0d meta %0d",
				$time, name, exp.rank, exp.meta, act.rank, act.meta);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (exp !== act)
		begin
			$display("FAIL t=%0t %s expected %0d, got %0d", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("FAIL t=%0t %s expected %b, got %b", $time, name, exp, act);
			mismatches++;
		end
	endtask

	// New entry goes behind every entry of equal rank
	task automatic model_insert(input entry_t e);
		int pos;
		pos = model.size();
		for (int i = 0; i < model.size(); i++)
		begin
			if (model[i].rank > e.rank)
			begin
				pos = i;
				break;
			end
		end
		model.insert(pos, e);
	endtask

	function automatic entry_t random_entry();
		entry_t e;
		logic [31:0] r;
		r = $urandom;
		e.rank = r[`PQ_RANK_WIDTH-1:0];
		r = $urandom;
		e.meta = r[`PQ_META_WIDTH-1:0];
		return e;
	endfunction

	function automatic entry_t make_entry(input int rank, input int meta);
		entry_t e;
		e.rank = rank[`PQ_RANK_WIDTH-1:0];
		e.meta = meta[`PQ_META_WIDTH-1:0];
		return e;
	endfunction

	task automatic send_entry(input entry_t e);
		int waited;
		logic accepted;
		waited = 0;
		in_entry = e;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		accepted = in_ready;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		if (accepted)
		begin
			model_insert(e);
			check_count("num_entries", count_t'(model.size()), num_entries);
		end
		else
		begin
			$display("Timeout: in_ready stayed low while sending rank %0d", e.rank);
			timeouts++;
		end
	endtask

	task automatic take_entry();
		int waited;
		logic taken;
		waited = 0;
		out_ready = 1'b1;
		@(negedge clk);
		while (!out_valid && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		taken = out_valid;
		if (taken && model.size() > 0)
		begin
			check_entry("out_entry", model[0], out_entry);
		end
		@(posedge clk);
		#2;
		out_ready = 1'b0;
		if (!taken)
		begin
			$display("Timeout: out_valid stayed low while removing an entry");
			timeouts++;
		end
		else if (model.size() == 0)
		begin
			$display("Unexpected removal from a queue that should be empty");
			mismatches++;
		end
		else
		begin
			void'(model.pop_front());
			check_count("num_entries", count_t'(model.size()), num_entries);
		end
	endtask

	task automatic drain_queue();
		int n;
		n = model.size();
		for (int i = 0; i < n; i++)
		begin
			take_entry();
		end
	endtask

	task automatic idle_after_reset();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!in_ready && waited < WAIT_LIMIT)
		begin
			check_flag("out_valid", 1'b0, out_valid);
			@(negedge clk);
			waited++;
		end
		if (!in_ready)
		begin
			$display("Timeout: in_ready never rose after reset");
			timeouts++;
		end
		check_flag("out_valid", 1'b0, out_valid);
		check_count("num_entries", '0, num_entries);
		@(posedge clk);
		#2;
	endtask

	task automatic descending_in_bank();
		send_entry(make_entry(300, 1));
		send_entry(make_entry(200, 2));
		send_entry(make_entry(100, 3));
		drain_queue();
	endtask

	task automatic random_overflow();
		for (int i = 0; i < 20; i++)
		begin
			send_entry(random_entry());
		end
		drain_queue();
	endtask

	// Ties fill the bank first and the rest spill into the list
	task automatic equal_rank_order();
		for (int i = 0; i < 8; i++)
		begin
			send_entry(make_entry(7, i));
		end
		send_entry(make_entry(9, 20));
		send_entry(make_entry(9, 21));
		drain_queue();
	endtask

	task automatic hold_min_under_backpressure();
		int ranks[7] = '{500, 600, 400, 300, 200, 100, 50};
		foreach (ranks[i])
		begin
			send_entry(make_entry(ranks[i], 40 + i));
			check_entry("out_entry", model[0], out_entry);
		end
		// Minimum holds while nobody takes it
		repeat (5)
		begin
			@(negedge clk);
			check_entry("out_entry", model[0], out_entry);
		end
		@(posedge clk);
		#2;
		drain_queue();
	endtask

	task automatic fill_to_capacity();
		for (int i = 0; i < CAPACITY; i++)
		begin
			send_entry(random_entry());
		end
		check_count("num_entries", count_t'(CAPACITY), num_entries);
		repeat (100)
		begin
			@(negedge clk);
			check_flag("in_ready", 1'b0, in_ready);
		end
		@(posedge clk);
		#2;
		take_entry();
		send_entry(random_entry());
		drain_queue();
	endtask

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_entry = '0;
		out_ready = 1'b0;
		mismatches = 0;
		timeouts = 0;
		void'($urandom(32'hff5fe867));
		repeat (2)
		begin
			@(posedge clk);
		end
		#2;
		rst = 1'b0;

		idle_after_reset();
		descending_in_bank();
		random_overflow();
		equal_rank_order();
		hold_min_under_backpressure();
		fill_to_capacity();

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
